// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_roce_tx_header_insert
FILELIST := roce_tx_header_insert.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: common/axis_beat_pkg.sv
// AXI-Stream beat sideband types and byte-lane helpers
`include "roce_tx_params.svh"

package axis_beat_pkg;

    typedef logic [`DATA_W-1:0]     tdata_t;
    typedef logic [`KEEP_W-1:0]     tkeep_t;
    typedef logic [`ID_W-1:0]       tid_t;
    typedef logic [`DEST_W-1:0]     tdest_t;
    typedef logic [`USER_OUT_W-1:0] tuser_out_t;
    typedef logic [`PSN_W-1:0]      psn_t;

    // Keep mask with the low nbytes lanes set
    function automatic tkeep_t keep_low(input int unsigned nbytes);
        tkeep_t k;
        k = '0;
        for (int unsigned i = 0; i < `KEEP_W; i++) begin
            if (i < nbytes) begin
                k[i] = 1'b1;
            end
        end
        return k;
    endfunction

    // Held bytes go to the low lanes, data is pushed up by the same amount
    function automatic tdata_t merge_shift(input logic [`SHIFT_BYTES*8-1:0] held,
                                           input tdata_t data);
        return {data[`DATA_W-`SHIFT_BYTES*8-1:0], held};
    endfunction

endpackage

// File: common/roce_hdr_pkg.sv
// RoCEv2 metadata and transmit header layouts
`include "roce_tx_params.svh"

package roce_hdr_pkg;

    // Metadata carried above the low tuser bits, first field is the MSB
    typedef struct packed {
        logic [23:0] pkt_num;
        logic [31:0] rsvd;
        logic [63:0] vaddr;
        logic [31:0] dst_ip;
        logic [47:0] dst_mac;
        logic [15:0] udp_src_port;
        logic [23:0] dst_qpn;
        logic [7:0]  opcode;
    } roce_meta_t;

    // Full 74-byte header, header byte 0 lands in bits 7:0
    typedef struct packed {
        // RETH
        logic [31:0]         reth_dma_len;
        logic [63:0]         reth_vaddr;
        // DETH
        logic [23:0]         deth_src_qpn;
        logic [7:0]          deth_rsvd;
        // BTH
        logic [`PSN_W-1:0]   bth_psn;
        logic [7:0]          bth_rsvd1;
        logic [23:0]         bth_dst_qpn;
        logic [31:0]         bth_rsvd0;
        logic [7:0]          bth_opcode;
        // UDP
        logic [15:0]         udp_csum;
        logic [15:0]         udp_len;
        logic [15:0]         udp_dst_port;
        logic [15:0]         udp_src_port;
        // IPv4
        logic [31:0]         ip_rsvd2;
        logic [31:0]         ip_dst;
        logic [31:0]         ip_src;
        logic [63:0]         ip_rsvd1;
        logic [15:0]         ip_total_len;
        logic [7:0]          ip_rsvd0;
        logic [3:0]          ip_ihl;
        logic [3:0]          ip_version;
        // Ethernet
        logic [15:0]         ethertype;
        logic [47:0]         src_mac;
        logic [47:0]         dst_mac;
    } roce_hdr_t;

endpackage

// File: common/roce_tx_params.svh
// RoCEv2 transmit header inserter widths, protocol constants and register map
`ifndef ROCE_TX_PARAMS_SVH
`define ROCE_TX_PARAMS_SVH

// Stream geometry
`define DATA_W          512
`define KEEP_W          (`DATA_W / 8)
`define ID_W            12
`define DEST_W          4
`define USER_OUT_W      17
`define META_W          248
`define TUSER_IN_W      (`USER_OUT_W + `META_W)

// Header geometry, 74 bytes spill 10 bytes into the second beat
`define HDR_W           592
`define HDR_BYTES       74
`define SHIFT_BYTES     (`HDR_BYTES - `KEEP_W)
`define PSN_W           24

// Protocol constants
`define ETHERTYPE_IPV4  16'h0800
`define IP_VER          4'd4
`define IP_IHL          4'd6
`define IP_TOTAL_LEN    16'd1088
`define UDP_ROCE_PORT   16'd4791
`define UDP_LEN         16'd1052
`define RETH_DMA_LEN    32'd1024
`define PKT_SHIFT       10

// Register port and map, byte offsets within the low address byte
`define REG_ADDR_W      16
`define REG_DATA_W      32
`define HDR_WORDS       19
`define REG_HDR_BASE    8'h00
`define REG_PSN         8'h4C
`define REG_VERSION     8'h50
`define REG_CLEAR       8'h54
`define VERSION_WORD    32'h2024_0320

`endif

// File: design/beat_realign.sv
// Header beat insertion and 10-byte payload realignment for the transmit stream
`timescale 1ns/1ps
`include "roce_tx_params.svh"

module beat_realign
    import axis_beat_pkg::*;
    import roce_hdr_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  tdata_t     s_tdata,
    input  tkeep_t     s_tkeep,
    input  logic       s_tvalid,
    output logic       s_tready,
    input  logic       s_tlast,
    input  tid_t       s_tid,
    input  tdest_t     s_tdest,
    input  tuser_out_t s_tuser,

    output tdata_t     m_tdata,
    output tkeep_t     m_tkeep,
    output logic       m_tvalid,
    input  logic       m_tready,
    output logic       m_tlast,
    output tid_t       m_tid,
    output tdest_t     m_tdest,
    output tuser_out_t m_tuser,

    input  roce_hdr_t  hdr_now,
    input  roce_hdr_t  hdr_held,
    output logic       hdr_capture,
    output logic       pkt_done
);

    localparam int HOLD_W = `SHIFT_BYTES * 8;

    typedef enum logic [1:0] {
        ST_HEAD,
        ST_BODY,
        ST_TAIL
    } state_t;

    state_t            state;
    logic              first_body;
    logic [HOLD_W-1:0] hold_q;
    logic [HOLD_W-1:0] held_bytes;
    tid_t              tid_q;
    tdest_t            tdest_q;
    tuser_out_t        tuser_q;
    logic              head_fire;
    logic              body_fire;
    logic              tail_fire;

    assign head_fire   = (state == ST_HEAD) && s_tvalid && m_tready;
    assign body_fire   = (state == ST_BODY) && s_tvalid && m_tready;
    assign tail_fire   = (state == ST_TAIL) && m_tready;
    assign hdr_capture = head_fire;
    assign pkt_done    = tail_fire;

    // First body beat carries the header spill, later ones the previous input tail
    assign held_bytes = first_body ? hdr_held[`HDR_W-1 -: HOLD_W] : hold_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_HEAD;
            first_body <= 1'b0;
        end else begin
            case (state)
                ST_HEAD: begin
                    if (head_fire) begin
                        state      <= ST_BODY;
                        first_body <= 1'b1;
                    end
                end
                ST_BODY: begin
                    if (body_fire) begin
                        first_body <= 1'b0;
                        if (s_tlast) begin
                            state <= ST_TAIL;
                        end
                    end
                end
                ST_TAIL: begin
                    if (tail_fire) begin
                        state <= ST_HEAD;
                    end
                end
                default: state <= ST_HEAD;
            endcase
        end
    end

    // Top 10 input bytes wait for the next output beat
    always_ff @(posedge clk) begin
        if (body_fire) begin
            hold_q <= s_tdata[`DATA_W-1 -: HOLD_W];
        end
        if (head_fire) begin
            tid_q   <= s_tid;
            tdest_q <= s_tdest;
            tuser_q <= s_tuser;
        end
    end

    always_comb begin
        m_tdata  = merge_shift(held_bytes, s_tdata);
        m_tkeep  = {s_tkeep[`KEEP_W-`SHIFT_BYTES-1:0], {`SHIFT_BYTES{1'b1}}};
        m_tvalid = s_tvalid;
        m_tlast  = 1'b0;
        s_tready = 1'b0;
        case (state)
            ST_HEAD: begin
                m_tdata = hdr_now[`DATA_W-1:0];
                m_tkeep = '1;
            end
            ST_BODY: begin
                s_tready = m_tready;
            end
            ST_TAIL: begin
                m_tdata  = merge_shift(held_bytes, '0);
                m_tkeep  = keep_low(`SHIFT_BYTES);
                m_tvalid = 1'b1;
                m_tlast  = 1'b1;
            end
            default: begin
                m_tvalid = 1'b0;
            end
        endcase
        // Nothing leaves while the block is held in reset
        if (rst) begin
            m_tvalid = 1'b0;
        end
    end

    // Sideband passes through on the head beat, then stays latched
    assign m_tid   = (state == ST_HEAD) ? s_tid   : tid_q;
    assign m_tdest = (state == ST_HEAD) ? s_tdest : tdest_q;
    assign m_tuser = (state == ST_HEAD) ? s_tuser : tuser_q;

endmodule

// File: design/roce_debug_regs.sv
// Debug register block for header readback, PSN status and PSN clear
`timescale 1ns/1ps
`include "roce_tx_params.svh"

module roce_debug_regs
    import axis_beat_pkg::*;
    import roce_hdr_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`REG_ADDR_W-1:0]    reg_wr_addr,
    input  logic [`REG_DATA_W-1:0]    reg_wr_data,
    input  logic [`REG_DATA_W/8-1:0]  reg_wr_strb,
    input  logic                      reg_wr_en,
    input  logic [`REG_ADDR_W-1:0]    reg_rd_addr,
    input  logic                      reg_rd_en,
    output logic [`REG_DATA_W-1:0]    reg_rd_data,
    output logic                      reg_rd_ack,
    output logic                      reg_wr_ack,
    input  roce_hdr_t                 hdr_held,
    input  psn_t                      psn,
    output logic                      psn_clear
);

    logic [`HDR_WORDS*`REG_DATA_W-1:0] hdr_words;
    logic [7:0]                        rd_off;
    logic [7:0]                        hdr_off;
    logic [`REG_DATA_W-1:0]            rd_mux;

    // Last header word only has 16 valid bits
    assign hdr_words = {{(`HDR_WORDS*`REG_DATA_W-`HDR_W){1'b0}}, hdr_held};
    assign rd_off    = reg_rd_addr[7:0];
    assign hdr_off   = rd_off - `REG_HDR_BASE;

    always_comb begin
        rd_mux = '0;
        case (rd_off)
            `REG_PSN:     rd_mux = {{(`REG_DATA_W-`PSN_W){1'b0}}, psn};
            `REG_VERSION: rd_mux = `VERSION_WORD;
            `REG_CLEAR:   rd_mux = {{(`REG_DATA_W-1){1'b0}}, psn_clear};
            default: begin
                if (hdr_off < `HDR_WORDS * 4 && hdr_off[1:0] == 2'b00) begin
                    rd_mux = hdr_words[hdr_off[7:2]*`REG_DATA_W +: `REG_DATA_W];
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reg_rd_en) begin
            reg_rd_data <= rd_mux;
        end
    end

    // Clear flag lives in the low byte lane
    always_ff @(posedge clk) begin
        if (rst) begin
            psn_clear  <= 1'b0;
            reg_rd_ack <= 1'b0;
            reg_wr_ack <= 1'b0;
        end else begin
            reg_rd_ack <= reg_rd_en;
            reg_wr_ack <= reg_wr_en;
            if (reg_wr_en && reg_wr_addr[7:0] == `REG_CLEAR && reg_wr_strb[0]) begin
                psn_clear <= reg_wr_data[0];
            end
        end
    end

endmodule

// File: design/roce_hdr_gen.sv
// RoCEv2 header generator with per-packet capture and PSN counter
`timescale 1ns/1ps
`include "roce_tx_params.svh"

module roce_hdr_gen
    import axis_beat_pkg::*;
    import roce_hdr_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  roce_meta_t s_tuser_meta,
    input  tid_t       s_tid,
    input  logic       hdr_capture,
    input  logic       pkt_done,
    input  logic       psn_clear,
    output roce_hdr_t  hdr_now,
    output roce_hdr_t  hdr_held,
    output psn_t       psn
);

    logic [63:0] reth_addr;

    // Each packet number strides one DMA block past the base address
    assign reth_addr = s_tuser_meta.vaddr + (64'(s_tuser_meta.pkt_num) << `PKT_SHIFT);

    always_comb begin
        hdr_now = '0;

        // Ethernet, source MAC left zero
        hdr_now.dst_mac      = s_tuser_meta.dst_mac;
        hdr_now.src_mac      = '0;
        hdr_now.ethertype    = `ETHERTYPE_IPV4;

        // IPv4
        hdr_now.ip_version   = `IP_VER;
        hdr_now.ip_ihl       = `IP_IHL;
        hdr_now.ip_total_len = `IP_TOTAL_LEN;
        hdr_now.ip_src       = '0;
        hdr_now.ip_dst       = s_tuser_meta.dst_ip;

        // UDP, checksum not computed
        hdr_now.udp_src_port = s_tuser_meta.udp_src_port;
        hdr_now.udp_dst_port = `UDP_ROCE_PORT;
        hdr_now.udp_len      = `UDP_LEN;
        hdr_now.udp_csum     = '0;

        // BTH
        hdr_now.bth_opcode   = s_tuser_meta.opcode;
        hdr_now.bth_dst_qpn  = s_tuser_meta.dst_qpn;
        hdr_now.bth_psn      = psn;

        // DETH source QP comes from the stream id
        hdr_now.deth_src_qpn = 24'(s_tid);

        // RETH
        hdr_now.reth_vaddr   = reth_addr;
        hdr_now.reth_dma_len = `RETH_DMA_LEN;
    end

    // Snapshot for register readback and the header spill beat
    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_held <= '0;
        end else if (hdr_capture) begin
            hdr_held <= hdr_now;
        end
    end

    // Counts finished packets, clear wins over increment
    always_ff @(posedge clk) begin
        if (rst) begin
            psn <= '0;
        end else if (psn_clear) begin
            psn <= '0;
        end else if (pkt_done) begin
            psn <= psn + 1'b1;
        end
    end

endmodule

// File: design/roce_tx_header_insert.sv
// RoCEv2 transmit header inserter top level for one 512-bit stream
`timescale 1ns/1ps
`include "roce_tx_params.svh"

module roce_tx_header_insert
    import axis_beat_pkg::*;
    import roce_hdr_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    // Payload stream with metadata in tuser
    input  tdata_t                    s_tdata,
    input  tkeep_t                    s_tkeep,
    input  logic                      s_tvalid,
    output logic                      s_tready,
    input  logic                      s_tlast,
    input  tid_t                      s_tid,
    input  tdest_t                    s_tdest,
    input  logic [`TUSER_IN_W-1:0]    s_tuser,

    // Framed stream toward the MAC
    output tdata_t                    m_tdata,
    output tkeep_t                    m_tkeep,
    output logic                      m_tvalid,
    input  logic                      m_tready,
    output logic                      m_tlast,
    output tid_t                      m_tid,
    output tdest_t                    m_tdest,
    output tuser_out_t                m_tuser,

    // Register port
    input  logic [`REG_ADDR_W-1:0]    reg_wr_addr,
    input  logic [`REG_DATA_W-1:0]    reg_wr_data,
    input  logic [`REG_DATA_W/8-1:0]  reg_wr_strb,
    input  logic                      reg_wr_en,
    output logic                      reg_wr_ack,
    input  logic [`REG_ADDR_W-1:0]    reg_rd_addr,
    input  logic                      reg_rd_en,
    output logic [`REG_DATA_W-1:0]    reg_rd_data,
    output logic                      reg_rd_ack
);

    roce_hdr_t hdr_now;
    roce_hdr_t hdr_held;
    psn_t      psn;
    logic      hdr_capture;
    logic      pkt_done;
    logic      psn_clear;

    roce_hdr_gen u_hdr_gen (
        .clk          (clk),
        .rst          (rst),
        .s_tuser_meta (s_tuser[`TUSER_IN_W-1:`USER_OUT_W]),
        .s_tid        (s_tid),
        .hdr_capture  (hdr_capture),
        .pkt_done     (pkt_done),
        .psn_clear    (psn_clear),
        .hdr_now      (hdr_now),
        .hdr_held     (hdr_held),
        .psn          (psn)
    );

    beat_realign u_realign (
        .clk         (clk),
        .rst         (rst),
        .s_tdata     (s_tdata),
        .s_tkeep     (s_tkeep),
        .s_tvalid    (s_tvalid),
        .s_tready    (s_tready),
        .s_tlast     (s_tlast),
        .s_tid       (s_tid),
        .s_tdest     (s_tdest),
        .s_tuser     (s_tuser[`USER_OUT_W-1:0]),
        .m_tdata     (m_tdata),
        .m_tkeep     (m_tkeep),
        .m_tvalid    (m_tvalid),
        .m_tready    (m_tready),
        .m_tlast     (m_tlast),
        .m_tid       (m_tid),
        .m_tdest     (m_tdest),
        .m_tuser     (m_tuser),
        .hdr_now     (hdr_now),
        .hdr_held    (hdr_held),
        .hdr_capture (hdr_capture),
        .pkt_done    (pkt_done)
    );

    roce_debug_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .reg_wr_addr (reg_wr_addr),
        .reg_wr_data (reg_wr_data),
        .reg_wr_strb (reg_wr_strb),
        .reg_wr_en   (reg_wr_en),
        .reg_rd_addr (reg_rd_addr),
        .reg_rd_en   (reg_rd_en),
        .reg_rd_data (reg_rd_data),
        .reg_rd_ack  (reg_rd_ack),
        .reg_wr_ack  (reg_wr_ack),
        .hdr_held    (hdr_held),
        .psn         (psn),
        .psn_clear   (psn_clear)
    );

endmodule

// File: roce_tx_header_insert.f
+incdir+common
common/roce_hdr_pkg.sv
common/axis_beat_pkg.sv
design/roce_hdr_gen.sv
design/beat_realign.sv
design/roce_debug_regs.sv
design/roce_tx_header_insert.sv
testbench/roce_tx_header_insert_assert.sv
testbench/tb_roce_tx_header_insert.sv

// File: testbench/roce_tx_header_insert_assert.sv
// Protocol assertions bound to the RoCEv2 transmit header inserter
`timescale 1ns/1ps

module roce_tx_header_insert_assert (
    input logic         clk,
    input logic         rst,
    input logic [511:0] m_tdata,
    input logic [63:0]  m_tkeep,
    input logic         m_tvalid,
    input logic         m_tready,
    input logic         m_tlast,
    input logic [11:0]  m_tid,
    input logic [3:0]   m_tdest,
    input logic [16:0]  m_tuser,
    input logic         reg_wr_en,
    input logic         reg_wr_ack,
    input logic         reg_rd_en,
    input logic         reg_rd_ack
);

    // Stalled beat holds until the sink takes it
    a_m_hold: assert property (@(posedge clk) disable iff (rst)
        (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata) && $stable(m_tkeep)
            && $stable(m_tlast) && $stable(m_tid) && $stable(m_tdest) && $stable(m_tuser)))
        else $error("m stream changed while stalled");

    a_wr_ack: assert property (@(posedge clk) disable iff (rst)
        reg_wr_en |=> reg_wr_ack)
        else $error("write acknowledge missing one cycle after enable");

    a_wr_ack_src: assert property (@(posedge clk) disable iff (rst)
        reg_wr_ack |-> $past(reg_wr_en))
        else $error("write acknowledge without a preceding enable");

    a_rd_ack: assert property (@(posedge clk) disable iff (rst)
        reg_rd_en |=> reg_rd_ack)
        else $error("read acknowledge missing one cycle after enable");

    a_rd_ack_src: assert property (@(posedge clk) disable iff (rst)
        reg_rd_ack |-> $past(reg_rd_en))
        else $error("read acknowledge without a preceding enable");

    a_reset_idle: assert property (@(posedge clk) rst |-> !m_tvalid)
        else $error("m_tvalid high during reset");

endmodule

bind roce_tx_header_insert roce_tx_header_insert_assert u_assert (
    .clk        (clk),
    .rst        (rst),
    .m_tdata    (m_tdata),
    .m_tkeep    (m_tkeep),
    .m_tvalid   (m_tvalid),
    .m_tready   (m_tready),
    .m_tlast    (m_tlast),
    .m_tid      (m_tid),
    .m_tdest    (m_tdest),
    .m_tuser    (m_tuser),
    .reg_wr_en  (reg_wr_en),
    .reg_wr_ack (reg_wr_ack),
    .reg_rd_en  (reg_rd_en),
    .reg_rd_ack (reg_rd_ack)
);

// File: testbench/tb_roce_tx_header_insert.sv
// Testbench for the RoCEv2 transmit header inserter, packet table against a byte-stream model
`timescale 1ns/1ps

module tb_roce_tx_header_insert;

    localparam int TIMEOUT  = 200;
    localparam int NUM_ROWS = 7;

    typedef struct {
        int          beats;
        logic [7:0]  opcode;
        logic [23:0] dst_qpn;
        logic [15:0] src_port;
        logic [47:0] dst_mac;
        logic [31:0] dst_ip;
        logic [63:0] vaddr;
        logic [23:0] pkt_num;
        logic [11:0] tid;
        logic [3:0]  tdest;
        logic [16:0] tag;
        bit          stall;
        int          clr;
        logic [23:0] exp_psn;
    } row_t;

    // clr 1 writes the clear flag to 1 before the packet, clr 2 writes it back to 0
    row_t rows [0:NUM_ROWS-1] = '{
        '{1, 8'h64, 24'h000123, 16'hC001, 48'h02AA_BBCC_DDEE, 32'h0A00_0002,
          64'h0000_1000_0000_0000, 24'd0, 12'h011, 4'h1, 17'h00001, 0, 0, 24'd0},
        '{2, 8'h0A, 24'hABCDEF, 16'hC002, 48'h0211_2233_4455, 32'hC0A8_0101,
          64'h0000_0000_0000_0400, 24'd3, 12'hFFF, 4'hF, 17'h1FFFF, 1, 0, 24'd1},
        '{4, 8'h06, 24'h000001, 16'h1234, 48'hFFFF_FFFF_FFFF, 32'hFFFF_FFFF,
          64'h0000_7FFF_FFFF_FC00, 24'hFFFFFF, 12'h800, 4'h8, 17'h10000, 0, 0, 24'd2},
        '{3, 8'h81, 24'h555555, 16'hAAAA, 48'h0A0B_0C0D_0E0F, 32'h0102_0304,
          64'hFFFF_FFFF_FFFF_FC00, 24'd1, 12'h0AB, 4'h3, 17'h0A5A5, 1, 0, 24'd3},
        '{2, 8'h2A, 24'h00BEEF, 16'h4000, 48'h0200_0000_0001, 32'h0A0A_0A0A,
          64'h0000_0000_1234_5000, 24'd16, 12'h123, 4'h2, 17'h00ABC, 0, 1, 24'd0},
        '{1, 8'h11, 24'h0F0F0F, 16'h8001, 48'h0200_0000_0002, 32'h0B0B_0B0B,
          64'h0000_0001_0000_0000, 24'd255, 12'h456, 4'h5, 17'h1C3C3, 1, 2, 24'd0},
        '{4, 8'hFF, 24'hFFFFFF, 16'hFFFF, 48'h0200_0000_0003, 32'h0C0C_0C0C,
          64'h0000_0000_0000_0000, 24'h000400, 12'h789, 4'h9, 17'h05555, 1, 0, 24'd1}
    };

    logic         clk = 1'b0;
    logic         rst;
    logic [511:0] s_tdata;
    logic [63:0]  s_tkeep;
    logic         s_tvalid;
    logic         s_tready;
    logic         s_tlast;
    logic [11:0]  s_tid;
    logic [3:0]   s_tdest;
    logic [264:0] s_tuser;
    logic [511:0] m_tdata;
    logic [63:0]  m_tkeep;
    logic         m_tvalid;
    logic         m_tready;
    logic         m_tlast;
    logic [11:0]  m_tid;
    logic [3:0]   m_tdest;
    logic [16:0]  m_tuser;
    logic [15:0]  reg_wr_addr;
    logic [31:0]  reg_wr_data;
    logic [3:0]   reg_wr_strb;
    logic         reg_wr_en;
    logic         reg_wr_ack;
    logic [15:0]  reg_rd_addr;
    logic         reg_rd_en;
    logic [31:0]  reg_rd_data;
    logic         reg_rd_ack;

    int           errors = 0;
    int           timeouts = 0;
    int           seed = 5;
    int           cur_row;
    logic         clear_on;
    logic [511:0] payload [0:3];
    logic [7:0]   exp_bytes [0:383];
    logic [607:0] exp_hdr_words;

    roce_tx_header_insert u_roce_tx_header_insert (.*);

    always #2 clk = ~clk;

    // Header from the layout rule, byte 0 in the low bits
    function automatic logic [591:0] build_header(input int r, input logic [23:0] psn);
        logic [63:0] addr;
        addr = rows[r].vaddr + ({40'h0, rows[r].pkt_num} << 10);
        return {32'd1024, addr, 12'h000, rows[r].tid, 8'h00, psn, 8'h00, rows[r].dst_qpn,
                32'h0, rows[r].opcode, 16'h0000, 16'd1052, 16'd4791, rows[r].src_port,
                32'h0, rows[r].dst_ip, 32'h0, 64'h0, 16'd1088, 8'h00, 4'd6, 4'd4,
                16'h0800, 48'h0, rows[r].dst_mac};
    endfunction

    task automatic report_mismatch(input string sig, input logic [511:0] exp,
                                   input logic [511:0] got);
        $display("FAILED t=%0t %s row %0d exp %0h got %0h", $time, sig, cur_row, exp, got);
        errors++;
    endtask

    // Random payload, then header bytes followed by payload bytes
    task automatic prepare_packet(input int r);
        logic [591:0] hdr;
        hdr = build_header(r, rows[r].exp_psn);
        exp_hdr_words = {16'h0000, hdr};
        for (int b = 0; b < rows[r].beats; b++) begin
            for (int w = 0; w < 16; w++) begin
                payload[b][32*w +: 32] = $random(seed);
            end
        end
        for (int i = 0; i < 74; i++) begin
            exp_bytes[i] = hdr[8*i +: 8];
        end
        for (int i = 0; i < 64 * rows[r].beats; i++) begin
            exp_bytes[74 + i] = payload[i / 64][8*(i % 64) +: 8];
        end
    endtask

    task automatic drive_beats();
        int   t;
        logic accepted;
        s_tid   = rows[cur_row].tid;
        s_tdest = rows[cur_row].tdest;
        s_tkeep = '1;
        s_tuser = {rows[cur_row].pkt_num, 32'h0, rows[cur_row].vaddr, rows[cur_row].dst_ip,
                   rows[cur_row].dst_mac, rows[cur_row].src_port, rows[cur_row].dst_qpn,
                   rows[cur_row].opcode, rows[cur_row].tag};
        for (int b = 0; b < rows[cur_row].beats; b++) begin
            s_tvalid = 1'b1;
            s_tdata  = payload[b];
            s_tlast  = (b == rows[cur_row].beats - 1);
            accepted = 1'b0;
            t = 0;
            while (!accepted && t < TIMEOUT) begin
                @(posedge clk);
                accepted = s_tready;
                t++;
            end
            if (!accepted) begin
                $display("Input beat %0d of row %0d was never accepted", b, cur_row);
                timeouts++;
            end
            #1;
            // Later beats carry a different tag, only the first one counts
            s_tuser[16:0] = ~rows[cur_row].tag;
        end
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
        // Idle sideband differs from the packet's own
        s_tid    = ~rows[cur_row].tid;
        s_tdest  = ~rows[cur_row].tdest;
    endtask

    task automatic check_beats();
        int           beat;
        int           t;
        int           nbeats;
        logic [31:0]  rnd;
        logic [63:0]  exp_keep;
        logic [511:0] exp_data;
        logic [511:0] mask;
        nbeats = rows[cur_row].beats + 2;
        beat = 0;
        t = 0;
        while (beat < nbeats && t < TIMEOUT) begin
            @(posedge clk);
            t++;
            if (m_tvalid && m_tready) begin
                exp_keep = (beat == nbeats - 1) ? 64'h3FF : '1;
                for (int j = 0; j < 64; j++) begin
                    exp_data[8*j +: 8] = exp_keep[j] ? exp_bytes[64*beat + j] : 8'h00;
                    mask[8*j +: 8] = {8{exp_keep[j]}};
                end
                if ((m_tdata & mask) !== exp_data) begin
                    report_mismatch("m_tdata", exp_data, m_tdata & mask);
                end
                if (m_tkeep !== exp_keep) begin
                    report_mismatch("m_tkeep", exp_keep, m_tkeep);
                end
                if (m_tlast !== (beat == nbeats - 1)) begin
                    report_mismatch("m_tlast", beat == nbeats - 1, m_tlast);
                end
                if (m_tid !== rows[cur_row].tid) begin
                    report_mismatch("m_tid", rows[cur_row].tid, m_tid);
                end
                if (m_tdest !== rows[cur_row].tdest) begin
                    report_mismatch("m_tdest", rows[cur_row].tdest, m_tdest);
                end
                if (m_tuser !== rows[cur_row].tag) begin
                    report_mismatch("m_tuser", rows[cur_row].tag, m_tuser);
                end
                beat++;
                t = 0;
            end
            #1;
            rnd = $random(seed);
            m_tready = rows[cur_row].stall ? rnd[0] : 1'b1;
        end
        if (beat < nbeats) begin
            $display("Row %0d stopped after %0d of %0d output beats", cur_row, beat, nbeats);
            timeouts++;
        end
    endtask

    task automatic reg_write(input logic [15:0] addr, input logic [31:0] data);
        int t;
        reg_wr_addr = addr;
        reg_wr_data = data;
        reg_wr_strb = 4'hF;
        reg_wr_en   = 1'b1;
        @(posedge clk);
        #1;
        reg_wr_en = 1'b0;
        t = 0;
        while (!reg_wr_ack && t < TIMEOUT) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (!reg_wr_ack) begin
            $display("Write to 0x%04h got no acknowledge", addr);
            timeouts++;
        end else if (t != 0) begin
            $display("Write acknowledge at 0x%04h came %0d cycles late", addr, t);
            errors++;
        end
    endtask

    task automatic check_read(input logic [15:0] addr, input logic [31:0] exp);
        int t;
        reg_rd_addr = addr;
        reg_rd_en   = 1'b1;
        @(posedge clk);
        #1;
        reg_rd_en = 1'b0;
        t = 0;
        while (!reg_rd_ack && t < TIMEOUT) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (!reg_rd_ack) begin
            $display("Read of 0x%04h got no acknowledge", addr);
            timeouts++;
        end else begin
            if (t != 0) begin
                $display("Read acknowledge at 0x%04h came %0d cycles late", addr, t);
                errors++;
            end
            if (reg_rd_data !== exp) begin
                $display("FAILED t=%0t reg_rd_data at 0x%04h exp %08h got %08h",
                         $time, addr, exp, reg_rd_data);
                errors++;
            end
        end
    endtask

    initial begin
        rst         = 1'b1;
        s_tdata     = '0;
        s_tkeep     = '0;
        // Input valid stays high through reset
        s_tvalid    = 1'b1;
        s_tlast     = 1'b0;
        s_tid       = '0;
        s_tdest     = '0;
        s_tuser     = '0;
        m_tready    = 1'b0;
        reg_wr_addr = '0;
        reg_wr_data = '0;
        reg_wr_strb = '0;
        reg_wr_en   = 1'b0;
        reg_rd_addr = '0;
        reg_rd_en   = 1'b0;
        clear_on    = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst      = 1'b0;
        s_tvalid = 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            cur_row = r;
            if (rows[r].clr != 0) begin
                clear_on = (rows[r].clr == 1);
                reg_write(16'h0054, {31'h0, clear_on});
                check_read(16'h0054, {31'h0, clear_on});
            end
            prepare_packet(r);
            m_tready = 1'b1;
            fork
                drive_beats();
                check_beats();
            join
            // Counter holds at zero while the clear flag is set
            check_read(16'h004C, clear_on ? 32'h0 : {8'h00, rows[r].exp_psn + 24'd1});
            for (int w = 0; w < 19; w++) begin
                check_read(16'(4 * w), exp_hdr_words[32*w +: 32]);
            end
        end

        check_read(16'h0050, 32'h2024_0320);
        check_read(16'h00F0, 32'h0000_0000);

        $display("Run finished with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
